/* verilog/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////
	// widths and ids
	//////////////////////////////

	localparam int ADDR_W  = 8;
	localparam int DATA_W  = 32;
	localparam int CU_ID_W = 8;

	// responses carrying this id belong to the vertex job side
	localparam logic [CU_ID_W-1:0] VERTEX_CONTROL_ID = 8'd1;

	// register map, byte offsets
	localparam logic [ADDR_W-1:0] REG_CTRL         = 8'h00;
	localparam logic [ADDR_W-1:0] REG_NUM_VERTICES = 8'h04;
	localparam logic [ADDR_W-1:0] REG_NUM_EDGES    = 8'h08;
	localparam logic [ADDR_W-1:0] REG_STATUS       = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_VERTEX_COUNT = 8'h10;
	localparam logic [ADDR_W-1:0] REG_EDGE_COUNT   = 8'h14;

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic [31:0]        count_t;
	typedef logic [CU_ID_W-1:0] cu_id_t;

	typedef struct packed {
		logic [31:0] address;
		cu_id_t      cu_id;
		logic [7:0]  size;
	} read_cmd_t;

	typedef struct packed {
		logic       valid;
		cu_id_t     cu_id;
		logic [7:0] tag;
	} read_rsp_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// job setup going to the tracker
	typedef struct packed {
		logic   enable;
		count_t num_vertices;
		count_t num_edges;
	} job_cfg_t;

	typedef struct packed {
		logic   done;
		count_t vertex_count;
		count_t edge_count;
	} job_status_t;

endpackage

`default_nettype wire

/* verilog/cu_config_regs.sv */
`default_nettype none

module cu_config_regs (
	input  logic                clock,
	input  logic                rstn,
	input  cu_pkg::apb_req_t    apb_req,
	output cu_pkg::apb_rsp_t    apb_rsp,
	input  cu_pkg::job_status_t job_status,
	output cu_pkg::job_cfg_t    job_cfg,
	output logic                cu_enabled
);

	import cu_pkg::*;

	logic              ctrl_enable;
	count_t            num_vertices;
	count_t            num_edges;
	logic              access;
	logic              wr_access;
	logic              offset_hit;
	logic              read_only;
	logic [DATA_W-1:0] rd_data;

	// second phase of the transfer, pready is tied high
	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite && offset_hit && !read_only;

	//////////////////////////////
	// address decode and readback
	//////////////////////////////

	always_comb begin
		rd_data    = '0;
		offset_hit = 1'b1;
		read_only  = 1'b0;
		case (apb_req.paddr)
			REG_CTRL: begin
				rd_data = {{(DATA_W-1){1'b0}}, ctrl_enable};
			end
			REG_NUM_VERTICES: begin
				rd_data = num_vertices;
			end
			REG_NUM_EDGES: begin
				rd_data = num_edges;
			end
			REG_STATUS: begin
				rd_data   = {{(DATA_W-1){1'b0}}, job_status.done};
				read_only = 1'b1;
			end
			REG_VERTEX_COUNT: begin
				rd_data   = job_status.vertex_count;
				read_only = 1'b1;
			end
			REG_EDGE_COUNT: begin
				rd_data   = job_status.edge_count;
				read_only = 1'b1;
			end
			default: begin
				offset_hit = 1'b0;
			end
		endcase
	end

	assign apb_rsp = '{
		prdata:  (access && !apb_req.pwrite) ? rd_data : '0,
		pready:  1'b1,
		pslverr: access && (!offset_hit || (apb_req.pwrite && read_only))
	};

	//////////////////////////////
	// writable registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ctrl_enable  <= 1'b0;
			num_vertices <= '0;
			num_edges    <= '0;
		end else if (wr_access) begin
			case (apb_req.paddr)
				REG_CTRL:         ctrl_enable  <= apb_req.pwdata[0];
				REG_NUM_VERTICES: num_vertices <= apb_req.pwdata;
				REG_NUM_EDGES:    num_edges    <= apb_req.pwdata;
				default: ;
			endcase
		end
	end

	// an empty job never enables the datapath
	assign cu_enabled = ctrl_enable && (num_vertices != '0);

	assign job_cfg = '{
		enable:       ctrl_enable,
		num_vertices: num_vertices,
		num_edges:    num_edges
	};

endmodule

`default_nettype wire

/* verilog/cu_read_arbiter.sv */
`default_nettype none

module cu_read_arbiter #(
	parameter type payload_t = cu_pkg::read_cmd_t
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled,
	input  logic [1:0] req_valid,
	input  payload_t   req_data [2],
	output logic [1:0] req_ready,
	output logic       out_valid,
	output payload_t   out_data,
	input  logic       out_ready
);

	logic last_grant;
	logic other;
	logic pick;
	logic slot_free;
	logic grant;

	assign other = ~last_grant;

	// the requester not served last wins a tie
	assign pick = (req_valid[other] || !req_valid[last_grant]) ? other : last_grant;

	// slot is empty or drains on this edge
	assign slot_free = !out_valid || out_ready;
	assign grant     = enabled && slot_free && req_valid[pick];

	always_comb begin
		req_ready       = 2'b00;
		req_ready[pick] = enabled && slot_free;
	end

	//////////////////////////////
	// output slot
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid  <= 1'b0;
			last_grant <= 1'b1;
		end else if (grant) begin
			out_valid  <= 1'b1;
			last_grant <= pick;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// payload only loads on a grant, so it holds under back-pressure
	always_ff @(posedge clock) begin
		if (grant) begin
			out_data <= req_data[pick];
		end
	end

endmodule

`default_nettype wire

/* verilog/cu_response_router.sv */
`default_nettype none

module cu_response_router (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  cu_pkg::read_rsp_t rsp_in,
	output cu_pkg::read_rsp_t rsp_vertex,
	output cu_pkg::read_rsp_t rsp_graph
);

	import cu_pkg::*;

	logic      to_vertex;
	logic      vertex_valid_q;
	logic      graph_valid_q;
	read_rsp_t rsp_q;

	assign to_vertex = (rsp_in.cu_id == VERTEX_CONTROL_ID);

	// responses are dropped while the unit is off
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid_q <= 1'b0;
			graph_valid_q  <= 1'b0;
		end else begin
			vertex_valid_q <= enabled && rsp_in.valid && to_vertex;
			graph_valid_q  <= enabled && rsp_in.valid && !to_vertex;
		end
	end

	always_ff @(posedge clock) begin
		rsp_q <= rsp_in;
	end

	// same payload on both sides, only one valid
	assign rsp_vertex = '{valid: vertex_valid_q, cu_id: rsp_q.cu_id, tag: rsp_q.tag};
	assign rsp_graph  = '{valid: graph_valid_q, cu_id: rsp_q.cu_id, tag: rsp_q.tag};

endmodule

`default_nettype wire

/* verilog/cu_progress_tracker.sv */
`default_nettype none

module cu_progress_tracker (
	input  logic                clock,
	input  logic                rstn,
	input  cu_pkg::job_cfg_t    job_cfg,
	input  logic                vertex_done,
	input  logic                edge_done,
	output cu_pkg::job_status_t job_status
);

	import cu_pkg::*;

	count_t vertex_count;
	count_t edge_count;
	logic   done;
	logic   totals_met;

	// an empty job never reports done
	assign totals_met = (job_cfg.num_vertices != '0)
		&& (vertex_count == job_cfg.num_vertices)
		&& (edge_count == job_cfg.num_edges);

	//////////////////////////////
	// completion counters
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count <= '0;
			edge_count   <= '0;
			done         <= 1'b0;
		end else if (!job_cfg.enable) begin
			// disabling the job restarts progress
			vertex_count <= '0;
			edge_count   <= '0;
			done         <= 1'b0;
		end else begin
			vertex_count <= vertex_count + count_t'(vertex_done);
			edge_count   <= edge_count + count_t'(edge_done);
			done         <= totals_met;
		end
	end

	assign job_status = '{
		done:         done,
		vertex_count: vertex_count,
		edge_count:   edge_count
	};

endmodule

`default_nettype wire

/* verilog/cu_control.sv */
`default_nettype none

module cu_control (
	input  logic                clock,
	input  logic                rstn,
	input  cu_pkg::apb_req_t    apb_req,
	output cu_pkg::apb_rsp_t    apb_rsp,
	input  logic [1:0]          cmd_valid,
	input  cu_pkg::read_cmd_t   cmd [2],
	output logic [1:0]          cmd_ready,
	output logic                out_valid,
	output cu_pkg::read_cmd_t   out_cmd,
	input  logic                out_ready,
	input  cu_pkg::read_rsp_t   read_rsp_in,
	output cu_pkg::read_rsp_t   rsp_vertex,
	output cu_pkg::read_rsp_t   rsp_graph,
	input  logic                vertex_done,
	input  logic                edge_done
);

	import cu_pkg::*;

	job_cfg_t    job_cfg;
	job_status_t job_status;
	logic        cu_enabled;

	cu_config_regs u_config_regs (
		.clock      (clock),
		.rstn       (rstn),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.job_status (job_status),
		.job_cfg    (job_cfg),
		.cu_enabled (cu_enabled)
	);

	// requester 0 is the vertex job side, 1 the graph algorithm
	cu_read_arbiter #(
		.payload_t (read_cmd_t)
	) u_read_arbiter (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (cu_enabled),
		.req_valid (cmd_valid),
		.req_data  (cmd),
		.req_ready (cmd_ready),
		.out_valid (out_valid),
		.out_data  (out_cmd),
		.out_ready (out_ready)
	);

	cu_response_router u_response_router (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (cu_enabled),
		.rsp_in     (read_rsp_in),
		.rsp_vertex (rsp_vertex),
		.rsp_graph  (rsp_graph)
	);

	cu_progress_tracker u_progress_tracker (
		.clock       (clock),
		.rstn        (rstn),
		.job_cfg     (job_cfg),
		.vertex_done (vertex_done),
		.edge_done   (edge_done),
		.job_status  (job_status)
	);

endmodule

`default_nettype wire

/* verif/cu_control_tb.sv */
`default_nettype none

module cu_control_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import cu_pkg::*;

	logic        clock = 1'b0;
	logic        rstn;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic [1:0]  cmd_valid;
	read_cmd_t   cmd [2];
	logic [1:0]  cmd_ready;
	logic        out_valid;
	read_cmd_t   out_cmd;
	logic        out_ready;
	read_rsp_t   read_rsp_in;
	read_rsp_t   rsp_vertex;
	read_rsp_t   rsp_graph;
	logic        vertex_done;
	logic        edge_done;
	integer      seed;
	logic [31:0] rd;
	logic        err;

	cu_control u_cu_control (.*);

	always #4 clock = ~clock;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out at %0t while waiting for %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	//////////////////////////////
	// apb master
	//////////////////////////////

	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int tries;
		tries = 0;
		@(negedge clock);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(negedge clock);
		apb_req.penable = 1'b1;
		#1;
		while (!apb_rsp.pready) begin
			if (tries == 16) report_timeout("pready");
			@(negedge clock);
			#1;
			tries++;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge clock);
		apb_req = '0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		apb_access(1'b1, addr, data, rd, err);
		check_equal(err, 0, "pslverr on register write");
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [31:0] expected,
		input string what);
		apb_access(1'b0, addr, '0, rd, err);
		check_equal(err, 0, "pslverr on register read");
		check_equal(rd, expected, what);
	endtask

	//////////////////////////////
	// stimulus phases
	//////////////////////////////

	// nothing may pass while the unit is off
	task automatic run_disabled(input int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clock);
			r           = rand32();
			cmd_valid   = r[1:0];
			out_ready   = r[2];
			read_rsp_in = '{valid: 1'b1, cu_id: r[15:8], tag: r[23:16]};
			#1;
			check_equal(cmd_ready, 0, "cmd_ready while disabled");
			check_equal(out_valid, 0, "out_valid while disabled");
			check_equal({rsp_vertex.valid, rsp_graph.valid}, 0, "router valid while disabled");
		end
		@(negedge clock);
		cmd_valid   = '0;
		read_rsp_in = '0;
		out_ready   = 1'b0;
	endtask

	task automatic run_traffic(input int per_req);
		read_cmd_t   req0_q [$];
		read_cmd_t   req1_q [$];
		read_cmd_t   slot_cmd;
		read_cmd_t   held;
		read_rsp_t   prev_rsp;
		logic        model_full;
		logic        last;
		logic        last_known;
		logic        held_valid;
		logic        drain;
		logic [1:0]  want;
		logic [31:0] r;
		int          cycles;
		for (int i = 0; i < per_req; i++) begin
			r = rand32();
			req0_q.push_back(read_cmd_t'{address: rand32(), cu_id: 8'd0, size: r[7:0]});
			req1_q.push_back(read_cmd_t'{address: rand32(), cu_id: 8'd1, size: r[15:8]});
		end
		prev_rsp   = '0;
		model_full = 1'b0;
		last       = 1'b0;
		last_known = 1'b0;
		held_valid = 1'b0;
		cycles     = 0;
		while (req0_q.size() != 0 || req1_q.size() != 0 || model_full) begin
			if (cycles == 4000) report_timeout("all read commands to leave the arbiter");
			@(negedge clock);
			check_equal(out_valid, model_full, "out_valid");
			if (held_valid) check_equal(out_cmd, held, "out_cmd held under back-pressure");
			// router output follows the response of the previous cycle
			check_equal(rsp_vertex.valid,
				prev_rsp.valid && prev_rsp.cu_id == VERTEX_CONTROL_ID, "rsp_vertex valid");
			check_equal(rsp_graph.valid,
				prev_rsp.valid && prev_rsp.cu_id != VERTEX_CONTROL_ID, "rsp_graph valid");
			if (prev_rsp.valid) begin
				check_equal(rsp_vertex.valid ? {rsp_vertex.cu_id, rsp_vertex.tag}
					: {rsp_graph.cu_id, rsp_graph.tag}, {prev_rsp.cu_id, prev_rsp.tag},
					"routed payload");
			end
			r            = rand32();
			cmd_valid[0] = req0_q.size() != 0 && r[1:0] != 2'b00;
			// graph side holds off until the first grant sets the pointer
			cmd_valid[1] = req1_q.size() != 0 && r[3:2] != 2'b00 && last_known;
			if (req0_q.size() != 0) cmd[0] = req0_q[0];
			if (req1_q.size() != 0) cmd[1] = req1_q[0];
			out_ready   = r[4];
			read_rsp_in = '{valid: r[5], cu_id: r[6] ? VERTEX_CONTROL_ID : r[15:8],
				tag: r[23:16]};
			#1;
			prev_rsp = read_rsp_in;
			drain    = model_full && out_ready;
			// expected grant from the round-robin rule
			if (model_full && !out_ready) begin
				want = 2'b00;
			end else if (cmd_valid == 2'b11) begin
				want = last ? 2'b01 : 2'b10;
			end else begin
				want = cmd_valid;
			end
			check_equal(cmd_ready & cmd_valid, want, "granted requesters");
			if (drain) check_equal(out_cmd, slot_cmd, "out_cmd leaving the arbiter");
			if (want != 2'b00) begin
				slot_cmd   = want[1] ? req1_q.pop_front() : req0_q.pop_front();
				last       = want[1];
				last_known = 1'b1;
				model_full = 1'b1;
			end else if (drain) begin
				model_full = 1'b0;
			end
			held_valid = out_valid && !out_ready;
			held       = out_cmd;
			cycles++;
		end
		@(negedge clock);
		cmd_valid   = '0;
		read_rsp_in = '0;
		out_ready   = 1'b0;
	endtask

	task automatic run_progress();
		logic [31:0] r;
		count_t      nv;
		count_t      ne;
		count_t      mv;
		count_t      me;
		int          cycles;
		r      = rand32();
		nv     = 32'(r[3:0]) + 1;
		ne     = 32'(r[12:8]);
		mv     = '0;
		me     = '0;
		cycles = 0;
		write_reg(REG_CTRL, 0);
		write_reg(REG_NUM_VERTICES, nv);
		write_reg(REG_NUM_EDGES, ne);
		write_reg(REG_CTRL, 1);
		while (mv != nv || me != ne) begin
			if (cycles == 500) report_timeout("completion pulses to reach the totals");
			@(negedge clock);
			r           = rand32();
			vertex_done = mv != nv && r[0];
			edge_done   = me != ne && r[1];
			mv          = mv + 32'(vertex_done);
			me          = me + 32'(edge_done);
			cycles++;
		end
		@(negedge clock);
		vertex_done = 1'b0;
		edge_done   = 1'b0;
		read_reg(REG_VERTEX_COUNT, mv, "vertex count");
		read_reg(REG_EDGE_COUNT, me, "edge count");
		cycles = 0;
		rd     = '0;
		while (!rd[0]) begin
			if (cycles == 20) report_timeout("done in REG_STATUS");
			apb_access(1'b0, REG_STATUS, '0, rd, err);
			cycles++;
		end
		write_reg(REG_CTRL, 0);
		read_reg(REG_VERTEX_COUNT, 0, "vertex count after disable");
		read_reg(REG_EDGE_COUNT, 0, "edge count after disable");
		read_reg(REG_STATUS, 0, "done after disable");
	endtask

	initial begin
		seed        = 32'ha56e_4734;
		rstn        = 1'b0;
		apb_req     = '0;
		cmd_valid   = '0;
		cmd[0]      = '0;
		cmd[1]      = '0;
		out_ready   = 1'b0;
		read_rsp_in = '0;
		vertex_done = 1'b0;
		edge_done   = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		check_equal({out_valid, cmd_ready, rsp_vertex.valid, rsp_graph.valid}, 0,
			"control outputs after reset");
		read_reg(REG_CTRL, 0, "enable after reset");
		read_reg(REG_STATUS, 0, "done after reset");

		// enable set with an empty job
		write_reg(REG_CTRL, 1);
		read_reg(REG_CTRL, 1, "enable readback");
		run_disabled(12);

		write_reg(REG_NUM_VERTICES, 32'h0000_3a11);
		write_reg(REG_NUM_EDGES, 32'h0001_7c02);
		read_reg(REG_NUM_VERTICES, 32'h0000_3a11, "vertex total readback");
		read_reg(REG_NUM_EDGES, 32'h0001_7c02, "edge total readback");
		write_reg(REG_CTRL, 0);
		read_reg(REG_CTRL, 0, "enable readback");
		run_disabled(12);

		apb_access(1'b0, 8'h18, '0, rd, err);
		check_equal(err, 1, "pslverr on unused offset");
		apb_access(1'b1, REG_STATUS, 32'h1, rd, err);
		check_equal(err, 1, "pslverr on write to status");

		write_reg(REG_CTRL, 1);
		run_traffic(60);
		run_progress();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
verilog/cu_pkg.sv
verilog/cu_config_regs.sv
verilog/cu_read_arbiter.sv
verilog/cu_response_router.sv
verilog/cu_progress_tracker.sv
verilog/cu_control.sv
verif/cu_control_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cu_control_tb -f list.f -o cu_control_sim

./obj_dir/cu_control_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log
